/* Makefile */
SIM      = verilator
VFLAGS   = --binary --timing -j 0
TOP      = tb_gb_io
FILELIST = vlog.f
OBJ_DIR  = obj_dir
PASS_MSG = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/gb_bus_ctrl.sv */
// ------------------------------
// bus control
// address decode, write strobes and read-data mux
// ------------------------------

module gb_bus_ctrl import gb_map_pkg::*; (
	input  logic               clk_cpu,
	input  logic               reset,
	input  addr_t              addr,
	input  logic               wr,
	input  logic               rd,
	output logic               joyp_wr,
	output logic               sb_wr,
	output logic               sc_wr,
	output logic               if_wr,
	output logic               ie_wr,
	output logic               wram_we,
	output logic               zp_we,
	output logic [WRAM_AW-1:0] wram_addr,
	output logic [ZP_AW-1:0]   zp_addr,
	input  data_t              joyp_q,
	input  data_t              sb_q,
	input  data_t              sc_q,
	input  data_t              if_q,
	input  data_t              ie_q,
	input  data_t              wram_q,
	input  data_t              zp_q,
	output data_t              rdata
);

	// c000-fdff, e000 and up echoes c000
	wire sel_wram = (addr[15:14] == 2'b11) && (addr[15:9] != 7'h7f);
	wire sel_zp   = (addr[15:7] == ZP_BASE_HI) && (addr != ADDR_IE);
	wire sel_joyp = addr == ADDR_JOYP;
	wire sel_sb   = addr == ADDR_SB;
	wire sel_sc   = addr == ADDR_SC;
	wire sel_if   = addr == ADDR_IF;
	wire sel_ie   = addr == ADDR_IE;

	logic  rsel_wram, rsel_zp; // ram select, latched with rd
	logic  rd_d;               // read data due this cycle
	data_t reg_mux, reg_val;
	data_t ram_mux, hold_q;

	assign wram_addr = addr[WRAM_AW-1:0]; // echo folds onto the same offset
	assign zp_addr   = addr[ZP_AW-1:0];

	assign joyp_wr = wr && sel_joyp;
	assign sb_wr   = wr && sel_sb;
	assign sc_wr   = wr && sel_sc;
	assign if_wr   = wr && sel_if;
	assign ie_wr   = wr && sel_ie;
	assign wram_we = wr && sel_wram;
	assign zp_we   = wr && sel_zp;

	// register side, sampled at the rd edge
	always_comb begin
		reg_mux = OPEN_BUS;
		if (sel_joyp)    reg_mux = joyp_q;
		else if (sel_sb) reg_mux = sb_q;
		else if (sel_sc) reg_mux = sc_q;
		else if (sel_if) reg_mux = {3'b111, if_q[4:0]}; // unused flag bits read 1
		else if (sel_ie) reg_mux = {3'b000, ie_q[4:0]};
	end

	// one-cycle-old select picks ram output or the captured register
	assign ram_mux = rsel_wram ? wram_q : rsel_zp ? zp_q : reg_val;
	assign rdata   = rd_d ? ram_mux : hold_q; // hold until next read

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			rd_d      <= 1'b0;
			rsel_wram <= 1'b0;
			rsel_zp   <= 1'b0;
			reg_val   <= OPEN_BUS;
			hold_q    <= OPEN_BUS;
		end else begin
			rd_d <= rd;
			if (rd) begin
				rsel_wram <= sel_wram;
				rsel_zp   <= sel_zp;
				reg_val   <= reg_mux;
			end
			if (rd_d)
				hold_q <= ram_mux;
		end
	end

endmodule

/* design/gb_io_top.sv */
// ------------------------------
// io and ram subsystem top
// bus decode, irq, joypad, serial, wram, zero page
// ------------------------------

module gb_io_top import gb_map_pkg::*; (
	input  logic       clk_cpu,
	input  logic       reset,
	input  addr_t      addr,
	input  data_t      wdata,
	input  logic       wr,
	input  logic       rd,
	output data_t      rdata,
	input  logic       vblank_pulse,
	input  logic       lcd_pulse,
	input  logic       timer_pulse,
	input  logic       irq_ack,
	input  logic [7:0] joystick,
	input  logic       serial_data_in,
	output logic       irq_n,
	output data_t      irq_vec,
	output logic       serial_clk_out,
	output logic       serial_data_out
);

	logic joyp_wr, sb_wr, sc_wr, if_wr, ie_wr, wram_we, zp_we;
	logic [WRAM_AW-1:0] wram_addr;
	logic [ZP_AW-1:0]   zp_addr;
	data_t joyp_q, sb_q, sc_q, if_q, ie_q, wram_q, zp_q;
	logic  joy_irq, ser_irq;

	gb_bus_ctrl u_bus (.clk_cpu, .reset, .addr, .wr, .rd, .joyp_wr, .sb_wr, .sc_wr,
		.if_wr, .ie_wr, .wram_we, .zp_we, .wram_addr, .zp_addr, .joyp_q, .sb_q,
		.sc_q, .if_q, .ie_q, .wram_q, .zp_q, .rdata);

	gb_irq_ctrl u_irq (.clk_cpu, .reset, .wdata, .if_wr, .ie_wr, .vblank_pulse,
		.lcd_pulse, .timer_pulse, .ser_irq, .joy_irq, .irq_ack, .if_q, .ie_q,
		.irq_n, .irq_vec);

	gb_joypad u_joy (.clk_cpu, .reset, .wdata, .joyp_wr, .joystick, .joyp_q, .joy_irq);

	gb_serial u_ser (.clk_cpu, .reset, .wdata, .sb_wr, .sc_wr, .serial_data_in,
		.sb_q, .sc_q, .ser_irq, .serial_clk_out, .serial_data_out);

	// work ram c000-dfff, echo handled in decode
	gb_spram #(.AW(WRAM_AW)) wram (.clk_cpu, .we(wram_we), .addr(wram_addr),
		.wdata, .q(wram_q));

	// zero page ff80-fffe
	gb_spram #(.AW(ZP_AW)) zpram (.clk_cpu, .we(zp_we), .addr(zp_addr),
		.wdata, .q(zp_q));

endmodule

/* design/gb_irq_ctrl.sv */
// ------------------------------
// interrupt controller
// IE/IF registers, priority vector, ack clear
// ------------------------------

module gb_irq_ctrl import gb_map_pkg::*, gb_irq_pkg::*; (
	input  logic  clk_cpu,
	input  logic  reset,
	input  data_t wdata,
	input  logic  if_wr,
	input  logic  ie_wr,
	input  logic  vblank_pulse,
	input  logic  lcd_pulse,
	input  logic  timer_pulse,
	input  logic  ser_irq,
	input  logic  joy_irq,
	input  logic  irq_ack,
	output data_t if_q,
	output data_t ie_q,
	output logic  irq_n,
	output data_t irq_vec
);

	irq_bits_t if_r, ie_r;
	irq_bits_t set_bits;
	irq_bits_t pending;
	irq_bits_t ack_mask; // lowest pending bit only

	always_comb begin
		set_bits             = '0;
		set_bits[IRQ_VBLANK] = vblank_pulse;
		set_bits[IRQ_LCD]    = lcd_pulse;
		set_bits[IRQ_TIMER]  = timer_pulse;
		set_bits[IRQ_SERIAL] = ser_irq;
		set_bits[IRQ_JOYPAD] = joy_irq;
	end

	assign pending  = if_r & ie_r;
	assign ack_mask = pending & (~pending + 5'd1); // isolate lowest set bit
	assign irq_n    = ~|pending;

	// lowest set bit wins, so scan from the top
	always_comb begin
		irq_vec = VEC_NONE;
		for (int i = IRQ_JOYPAD; i >= IRQ_VBLANK; i--) begin
			if (pending[i])
				irq_vec = VEC_BASE + VEC_STEP * 8'(i);
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r <= '0;
			ie_r <= '0;
		end else begin
			if (if_wr)
				if_r <= wdata[4:0]; // cpu write beats events and ack
			else
				if_r <= (if_r & ~(irq_ack ? ack_mask : '0)) | set_bits; // new event survives ack
			if (ie_wr)
				ie_r <= wdata[4:0];
		end
	end

	assign if_q = {3'b000, if_r};
	assign ie_q = {3'b000, ie_r};

endmodule

/* design/gb_irq_pkg.sv */
// ------------------------------
// interrupt and serial package
// flag bit positions, vectors and serial fsm
// ------------------------------

package gb_irq_pkg;

	typedef logic [4:0] irq_bits_t; // one bit per source

	// flag bit positions, bit 0 has top priority
	localparam int IRQ_VBLANK = 0;
	localparam int IRQ_LCD    = 1;
	localparam int IRQ_TIMER  = 2;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	localparam logic [7:0] VEC_BASE = 8'h40; // vblank entry
	localparam logic [7:0] VEC_STEP = 8'h08; // spacing of entries
	localparam logic [7:0] VEC_NONE = 8'h55; // nothing pending

	typedef enum logic [1:0] {SER_IDLE, SER_SHIFT, SER_DONE} ser_state_t;

	localparam logic [8:0] SER_DIV_MAX = 9'd511; // cycles per bit - 1
	localparam logic [8:0] SER_EDGE_AT = 9'd100; // shift clock falls here

endpackage

/* design/gb_joypad.sv */
// ------------------------------
// joypad register
// select bits, matrix read, press interrupt
// ------------------------------

module gb_joypad import gb_map_pkg::*; (
	input  logic       clk_cpu,
	input  logic       reset,
	input  data_t      wdata,
	input  logic       joyp_wr,
	input  logic [7:0] joystick, // active high buttons
	output data_t      joyp_q,
	output logic       joy_irq
);

	logic [1:0] p54;              // select, 0 = group enabled
	logic [3:0] lines;            // matrix lines, low = pressed
	logic [3:0] line_d1, line_d2; // sync chain

	assign lines   = (~joystick[3:0] | {4{p54[0]}}) & (~joystick[7:4] | {4{p54[1]}});
	assign joyp_q  = {2'b11, p54, lines};
	assign joy_irq = |(line_d2 & ~line_d1); // any line falling

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54     <= 2'b00;
			line_d1 <= 4'hf;
			line_d2 <= 4'hf;
		end else begin
			if (joyp_wr) p54 <= wdata[5:4];
			line_d1 <= lines;
			line_d2 <= line_d1;
		end
	end

endmodule

/* design/gb_map_pkg.sv */
// ------------------------------
// memory map package
// bus widths, address map and fixed read values
// ------------------------------

package gb_map_pkg;

	typedef logic [15:0] addr_t; // cpu address
	typedef logic [7:0]  data_t; // bus byte

	// io registers
	localparam addr_t ADDR_JOYP = 16'hff00;
	localparam addr_t ADDR_SB   = 16'hff01;
	localparam addr_t ADDR_SC   = 16'hff02;
	localparam addr_t ADDR_IF   = 16'hff0f;
	localparam addr_t ADDR_IE   = 16'hffff;

	localparam logic [8:0] ZP_BASE_HI = 9'h1ff; // addr[15:7] of ff80

	localparam int WRAM_AW = 13; // 8k work ram
	localparam int ZP_AW   = 7;  // 128 byte zero page, ffff is IE

	localparam data_t OPEN_BUS = 8'hff; // nothing mapped

endpackage

/* design/gb_serial.sv */
// ------------------------------
// serial port, internal clock master
// 8 bit shift, bit clock divider, done irq
// ------------------------------

module gb_serial import gb_map_pkg::*, gb_irq_pkg::*; (
	input  logic  clk_cpu,
	input  logic  reset,
	input  data_t wdata,
	input  logic  sb_wr,
	input  logic  sc_wr,
	input  logic  serial_data_in,
	output data_t sb_q,
	output data_t sc_q,
	output logic  ser_irq,
	output logic  serial_clk_out,
	output logic  serial_data_out
);

	ser_state_t state;
	data_t      sb_r;
	logic       sc_start, sc_clk; // SC bits 7 and 0
	logic [8:0] div;              // bit period counter
	logic [2:0] bit_cnt;          // bits left - 1
	logic       clk_out_r, data_out_r;

	wire bit_tick = (state == SER_SHIFT) && (div == 9'd0);

	assign sb_q            = sb_r;
	assign sc_q            = {sc_start, 6'h3f, sc_clk}; // unused bits high
	assign ser_irq         = state == SER_DONE;
	assign serial_clk_out  = clk_out_r;
	assign serial_data_out = data_out_r;

	// shift register, msb out and data in at the rising shift clock
	always_ff @(posedge clk_cpu) begin
		if (sb_wr)
			sb_r <= wdata;
		else if (bit_tick)
			sb_r <= {sb_r[6:0], serial_data_in};
	end

	// ------------------------------
	// transfer fsm
	// ------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			state      <= SER_IDLE;
			sc_start   <= 1'b0;
			sc_clk     <= 1'b0;
			div        <= SER_DIV_MAX;
			bit_cnt    <= 3'd0;
			clk_out_r  <= 1'b1; // idle high
			data_out_r <= 1'b1;
		end else if (sc_wr) begin
			sc_start  <= wdata[7];
			sc_clk    <= wdata[0];
			div       <= SER_DIV_MAX;
			bit_cnt   <= 3'd7;
			clk_out_r <= 1'b1;
			state     <= (wdata[7] && wdata[0]) ? SER_SHIFT : SER_IDLE; // ext clock not supported
		end else begin
			case (state)
				SER_SHIFT: begin
					div <= div - 9'd1;
					if (div == SER_EDGE_AT) clk_out_r <= 1'b0; // falling shift clock
					if (bit_tick) begin
						clk_out_r  <= 1'b1;
						data_out_r <= sb_r[7];
						div        <= SER_DIV_MAX;
						if (bit_cnt == 3'd0) state <= SER_DONE;
						else bit_cnt <= bit_cnt - 3'd1;
					end
				end
				SER_DONE: begin
					sc_start <= 1'b0; // same edge as IF bit 3
					state    <= SER_IDLE;
				end
				default: state <= SER_IDLE;
			endcase
		end
	end

endmodule

/* design/gb_spram.sv */
// ------------------------------
// single port ram, registered read
// ------------------------------

module gb_spram import gb_map_pkg::*; #(
	parameter int AW = 13
) (
	input  logic          clk_cpu,
	input  logic          we,
	input  logic [AW-1:0] addr,
	input  data_t         wdata,
	output data_t         q
);

	data_t mem [2**AW]; // contents random at power up

	always_ff @(posedge clk_cpu) begin
		if (we) mem[addr] <= wdata;
		q <= mem[addr]; // old data on a write cycle
	end

endmodule

/* dv/gb_io_checker.sv */
// ------------------------------
// io subsystem checker
// reference model, compares read returns, irq outputs and serial out
// ------------------------------

module gb_io_checker import gb_map_pkg::*, gb_irq_pkg::*; (
	input  logic       clk_cpu, reset, wr, rd, irq_ack,
	input  logic       vblank_pulse, lcd_pulse, timer_pulse,
	input  logic       irq_n, serial_clk_out, serial_data_out, serial_data_in,
	input  addr_t      addr,
	input  data_t      wdata, rdata, irq_vec,
	input  logic [7:0] joystick,
	output int         rd_errs, irq_errs, ser_errs
);

	data_t      wram_m [2**WRAM_AW]; // work ram image
	data_t      zp_m [2**ZP_AW];
	data_t      sb_m, exp_q;         // exp_q due the cycle after rd
	addr_t      exp_a;
	irq_bits_t  if_m, ie_m, pend, ev;
	logic [1:0] sel_m;               // joypad select, 0 = group on
	logic [3:0] d1_m, d2_m;          // press detect chain
	logic       sc7_m, sc0_m, busy, chk_rd, sclk_d, sdi_d;
	int         rises;               // shift clock rises this transfer

	// matrix lines, low = pressed on a selected group
	function automatic logic [3:0] lines_ref();
		logic [3:0] v;
		v = 4'hf;
		if (!sel_m[0]) v = v & ~joystick[3:0];
		if (!sel_m[1]) v = v & ~joystick[7:4];
		return v;
	endfunction

	function automatic data_t read_ref(addr_t a);
		if (a >= 16'hc000 && a < 16'hfe00) return wram_m[a[WRAM_AW-1:0]]; // echo included
		if (a >= 16'hff80 && a < 16'hffff) return zp_m[a[ZP_AW-1:0]];
		case (a)
			ADDR_JOYP: return {2'b11, sel_m, lines_ref()};
			ADDR_SB:   return sb_m;
			ADDR_SC:   return {sc7_m, 6'h3f, sc0_m};
			ADDR_IF:   return {3'b111, if_m};
			ADDR_IE:   return {3'b000, ie_m};
			default:   return OPEN_BUS;
		endcase
	endfunction

	// lowest pending bit has priority
	function automatic data_t vec_ref(irq_bits_t p);
		casez (p)
			5'b????1: return VEC_BASE;
			5'b???10: return VEC_BASE + VEC_STEP;
			5'b??100: return VEC_BASE + 8'd2 * VEC_STEP;
			5'b?1000: return VEC_BASE + 8'd3 * VEC_STEP;
			5'b10000: return VEC_BASE + 8'd4 * VEC_STEP;
			default:  return VEC_NONE;
		endcase
	endfunction

	// ------------------------------
	// sample mid cycle, model holds state of the current cycle
	// ------------------------------
	always @(negedge clk_cpu) begin
		if (reset) begin
			if_m     = '0;
			ie_m     = '0;
			sel_m    = 2'b00;
			d1_m     = 4'hf;
			d2_m     = 4'hf;
			sc7_m    = 1'b0;
			sc0_m    = 1'b0;
			busy     = 1'b0;
			rises    = 0;
			chk_rd   = 1'b1; // first cycle out of reset reads open bus
			exp_q    = OPEN_BUS;
			exp_a    = '0;
			rd_errs  = 0;
			irq_errs = 0;
			ser_errs = 0;
		end else begin
			if (chk_rd && rdata !== exp_q) begin
				rd_errs++;
				$display("** Error at %0t: read %h gave %h, expected %h",
					$time, exp_a, rdata, exp_q);
			end
			chk_rd = rd;
			exp_q  = read_ref(addr);
			exp_a  = addr;
			pend   = if_m & ie_m;
			if (irq_n !== (pend == '0) || irq_vec !== vec_ref(pend)) begin
				irq_errs++;
				$display("** Error at %0t: irq_n %b vec %h, pending flags %b",
					$time, irq_n, irq_vec, pend);
			end
			if (!busy && serial_clk_out !== 1'b1) begin // shift clock idles high
				ser_errs++;
				$display("** Error at %0t: serial_clk_out low while idle", $time);
			end
			ev = {|(d2_m & ~d1_m), 1'b0, timer_pulse, lcd_pulse, vblank_pulse};
			if (busy && serial_clk_out && !sclk_d) begin // rising shift clock
				if (serial_data_out !== sb_m[7]) begin
					ser_errs++;
					$display("** Error at %0t: serial_data_out %b on bit %0d, expected %b",
						$time, serial_data_out, rises, sb_m[7]);
				end
				sb_m = {sb_m[6:0], sdi_d};
				rises++;
				if (rises == 8) begin
					ev[IRQ_SERIAL] = 1'b1;
					sc7_m          = 1'b0;
					busy           = 1'b0;
				end
			end
			if (wr && addr == ADDR_IF)
				if_m = wdata[4:0]; // cpu write wins
			else begin
				if (irq_ack)
					if_m = if_m & ~(pend & ~(pend - 5'd1)); // drop lowest pending
				if_m = if_m | ev;
			end
			d2_m = d1_m;
			d1_m = lines_ref(); // old select
			if (wr) begin
				if (addr >= 16'hc000 && addr < 16'hfe00) wram_m[addr[WRAM_AW-1:0]] = wdata;
				if (addr >= 16'hff80 && addr < 16'hffff) zp_m[addr[ZP_AW-1:0]] = wdata;
				case (addr)
					ADDR_JOYP: sel_m = wdata[5:4];
					ADDR_SB:   sb_m = wdata;
					ADDR_IE:   ie_m = wdata[4:0];
					ADDR_SC: begin
						sc7_m = wdata[7];
						sc0_m = wdata[0];
						busy  = wdata[7] & wdata[0]; // internal clock start
						rises = 0;
					end
					default: ;
				endcase
			end
		end
		sclk_d = serial_clk_out;
		sdi_d  = serial_data_in; // value seen by the next rising shift clock
	end

endmodule

/* dv/tb_gb_io.sv */
// ------------------------------
// testbench for the io and ram subsystem
// bus tasks, stimulus sequence and run limit
// ------------------------------

module tb_gb_io import gb_map_pkg::*; ();

	// ram ops, register tests, two serial transfers, margin
	localparam int RUN_LIMIT = 64 * 2 + 400 + 2 * (8 * 512 + 64) + 1000;

	logic        clk_cpu = 1'b0;
	logic        reset, wr, rd, irq_ack;
	logic        vblank_pulse, lcd_pulse, timer_pulse;
	logic        serial_data_in = 1'b0;
	logic        irq_n, serial_clk_out, serial_data_out;
	addr_t       addr;
	data_t       wdata, rdata, irq_vec, rd_val;
	logic [7:0]  joystick, sdi_pat;
	logic [2:0]  sdi_idx = 3'd7;        // serial input bit, msb first
	logic        sclk_q = 1'b1;
	logic [31:0] rng = 32'h001a_9cf0;   // lcg state
	logic [31:0] r;
	addr_t       ram_a [32];
	int          cycles = 0;
	int          rd_errs, irq_errs, ser_errs;

	gb_io_top DUT (.*);
	gb_io_checker chk (.*);

	always #20 clk_cpu = ~clk_cpu;

	always @(posedge clk_cpu) begin
		cycles <= cycles + 1;
		if (cycles == RUN_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	// next serial input bit after each falling shift clock
	always @(posedge clk_cpu) begin
		sclk_q <= serial_clk_out;
		if (sclk_q && !serial_clk_out) begin
			serial_data_in <= sdi_pat[sdi_idx];
			sdi_idx        <= sdi_idx - 3'd1;
		end
	end

	function automatic logic [31:0] lcg_next();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	task automatic bus_write(input addr_t a, input data_t d);
		@(posedge clk_cpu);
		addr  <= a;
		wdata <= d;
		wr    <= 1'b1;
		@(posedge clk_cpu);
		wr    <= 1'b0;
	endtask

	task automatic bus_read(input addr_t a, output data_t d);
		@(posedge clk_cpu);
		addr <= a;
		rd   <= 1'b1;
		@(posedge clk_cpu);
		rd   <= 1'b0;
		@(negedge clk_cpu);
		d = rdata; // one cycle latency
	endtask

	task automatic pulse_events(input logic [3:0] ev); // {ack, timer, lcd, vblank}
		@(posedge clk_cpu);
		{irq_ack, timer_pulse, lcd_pulse, vblank_pulse} <= ev;
		@(posedge clk_cpu);
		{irq_ack, timer_pulse, lcd_pulse, vblank_pulse} <= 4'b0000;
	endtask

	task automatic serial_transfer(input data_t tx, input data_t rx);
		sdi_pat = rx;
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_SB, tx);
		bus_write(ADDR_SC, 8'h81); // start, internal clock
		rd_val = 8'h80;
		while (rd_val[7])
			bus_read(ADDR_SC, rd_val);
		bus_read(ADDR_IF, rd_val);
		bus_read(ADDR_SB, rd_val);
	endtask

	initial begin
		reset        = 1'b1;
		addr         = '0;
		wdata        = '0;
		wr           = 1'b0;
		rd           = 1'b0;
		irq_ack      = 1'b0;
		vblank_pulse = 1'b0;
		lcd_pulse    = 1'b0;
		timer_pulse  = 1'b0;
		joystick     = 8'h00;
		sdi_pat      = 8'h00;
		repeat (4) @(posedge clk_cpu);
		reset <= 1'b0;

		// work ram, half through the echo, then zero page
		for (int i = 0; i < 32; i++) begin
			r = lcg_next();
			if (i < 16)
				ram_a[i] = (r[31] ? 16'he000 : 16'hc000) + (r[15:0] % 16'h1e00);
			else
				ram_a[i] = 16'hff80 + (r[15:0] % 16'd127);
			bus_write(ram_a[i], r[23:16]);
		end
		for (int i = 0; i < 32; i++)
			bus_read(ram_a[i] ^ ((i < 16) ? 16'h2000 : 16'h0000), rd_val); // other alias

		bus_write(ADDR_IE, 8'hff);
		bus_read(ADDR_IE, rd_val);
		bus_write(ADDR_IF, 8'h0a);
		bus_read(ADDR_IF, rd_val);
		bus_read(16'h4000, rd_val);
		bus_read(16'hfe40, rd_val);
		bus_read(16'hff03, rd_val);
		bus_read(16'hff10, rd_val);
		bus_read(16'hff7f, rd_val);

		// priority and ack
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_IE, 8'h1f);
		pulse_events(4'b0110);     // timer + lcd
		pulse_events(4'b1000);     // ack takes lcd
		bus_read(ADDR_IF, rd_val);
		bus_write(ADDR_IE, 8'h04); // timer only
		pulse_events(4'b0001);
		pulse_events(4'b1000);     // vblank masked, timer goes
		bus_read(ADDR_IF, rd_val);
		pulse_events(4'b1001);     // new vblank beside an idle ack
		bus_read(ADDR_IF, rd_val);

		// joypad, one group selected per pass
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_IE, 8'h10);
		for (int i = 0; i < 4; i++) begin
			r = lcg_next();
			bus_write(ADDR_JOYP, {2'b00, i[0], ~i[0], 4'h0});
			@(posedge clk_cpu);
			joystick <= r[7:0] | 8'h11; // a press in each group
			repeat (4) @(posedge clk_cpu);
			bus_read(ADDR_JOYP, rd_val);
			bus_read(ADDR_IF, rd_val);
			@(posedge clk_cpu);
			joystick <= 8'h00;
			bus_write(ADDR_IF, 8'h00);
		end

		serial_transfer(8'hb4, 8'h5c);
		r = lcg_next();
		serial_transfer(r[7:0], r[15:8]);

		repeat (2) @(posedge clk_cpu);
		$display("read errors %0d, irq errors %0d, serial errors %0d",
			rd_errs, irq_errs, ser_errs);
		if (rd_errs + irq_errs + ser_errs == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* vlog.f */
design/gb_map_pkg.sv
design/gb_irq_pkg.sv
design/gb_spram.sv
design/gb_bus_ctrl.sv
design/gb_irq_ctrl.sv
design/gb_joypad.sv
design/gb_serial.sv
design/gb_io_top.sv
dv/gb_io_checker.sv
dv/tb_gb_io.sv
